//--- filelist.f
+incdir+include
hdl/ndn_pkt_pkg.sv
hdl/ndn_table_pkg.sv
hdl/pit_table.sv
hdl/content_buffer.sv
hdl/pit_controller.sv
hdl/ndn_node.sv
dv/clock_gen.sv
dv/ndn_node_tb.sv

//--- Makefile
SOURCES := $(shell grep -v '^+' filelist.f) include/ndn_macros.svh

.PHONY: run clean

run: obj_dir/Vndn_node_tb
	./obj_dir/Vndn_node_tb > sim.log 2>&1; cat sim.log
	grep -q '^\*\*\* PASSED \*\*\*$$' sim.log

obj_dir/Vndn_node_tb: filelist.f $(SOURCES)
	verilator --binary --timing -Wno-fatal -f filelist.f \
		--top-module ndn_node_tb -o Vndn_node_tb

clean:
	rm -rf obj_dir sim.log

//--- dv/ndn_node_tb.sv
`timescale 1ns/10ps
`include "ndn_macros.svh"

module ndn_node_tb;
	import ndn_pkt_pkg::*;

	localparam int RANDOM_EVENTS = 300;
	localparam int MAX_EVENTS = RANDOM_EVENTS + 20; // Directed events fit in the margin
	localparam int CYCLES_PER_EVENT = `NDN_SLOT_BYTES * 4 + 10;

	logic       clk;
	logic       reset;
	logic       event_start;
	ndn_event_t evt;
	logic       in_valid;
	ndn_byte_t  in_data;
	logic       busy;
	logic       forward_interest;
	ndn_name_t  forward_name;
	logic       unsolicited;
	logic       out_valid;
	ndn_byte_t  out_data;
	logic       satisfied;

	integer seed = 32'hdd7b_cd9c;
	int     errors = 0;
	int     checks = 0;
	int     events_done = 0;
	int     cycle = 0;

	// Reference PIT and content store
	logic                                m_valid [`NDN_SLOTS];
	logic                                m_received [`NDN_SLOTS];
	logic [`NDN_NAME_W-`NDN_INDEX_W-1:0] m_tag [`NDN_SLOTS];
	ndn_byte_t                           m_content [`NDN_SLOTS][`NDN_SLOT_BYTES];

	// What the monitor saw since the last comparison
	ndn_name_t fwd_seen [$];
	ndn_byte_t out_seen [$];
	int        out_cycle [$];
	int        unsol_seen = 0;

	clock_gen clock_i (
		.clk   (clk),
		.reset (reset)
	);

	ndn_node dut_i (
		.clk              (clk),
		.reset            (reset),
		.event_start      (event_start),
		.evt              (evt),
		.in_valid         (in_valid),
		.in_data          (in_data),
		.busy             (busy),
		.forward_interest (forward_interest),
		.forward_name     (forward_name),
		.unsolicited      (unsolicited),
		.out_valid        (out_valid),
		.out_data         (out_data),
		.satisfied        (satisfied)
	);

	task automatic check_value(input logic [31:0] expected, input logic [31:0] actual,
		input string what);
		checks++;
		if (expected !== actual)
		begin
			errors++;
			$display("Fail at %0t: %s, expected %0h, got %0h", $time, what, expected, actual);
		end
	endtask

	function automatic logic model_hit(input ndn_name_t name);
		logic [`NDN_INDEX_W-1:0] idx;
		idx = name[`NDN_INDEX_W-1:0];
		return m_valid[idx] && (m_tag[idx] == name[`NDN_NAME_W-1:`NDN_INDEX_W]);
	endfunction

	// Small pool of 4 slots and 3 tags so hits and collisions are common
	function automatic ndn_name_t pick_name();
		logic [`NDN_NAME_W-`NDN_INDEX_W-1:0] tag;
		logic [`NDN_INDEX_W-1:0]             idx;
		tag = 12'h0c0 + 12'({$random(seed)} % 3);
		idx = 4'({$random(seed)} % 4);
		return {tag, idx};
	endfunction

	always @(posedge clk)
	begin
		cycle++;
		if (out_valid)
		begin
			out_seen.push_back(out_data);
			out_cycle.push_back(cycle);
			check_value(1, satisfied, "satisfied while bytes stream out");
		end
		if (forward_interest)
			fwd_seen.push_back(forward_name);
		if (unsolicited)
			unsol_seen++;
	end

	task automatic send_event(input ndn_kind_t kind, input ndn_name_t name);
		@(posedge clk);
		while (busy)
			@(posedge clk);
		event_start <= 1'b1;
		evt.kind <= kind;
		evt.name <= name;
		@(posedge clk);
		event_start <= 1'b0; // Accepted on this edge
	endtask

	task automatic compare_outputs(input logic exp_fwd, input ndn_name_t name,
		input logic exp_serve, input int exp_unsol);
		logic [`NDN_INDEX_W-1:0] idx;
		int                      exp_bytes;
		idx = name[`NDN_INDEX_W-1:0];
		exp_bytes = exp_serve ? `NDN_SLOT_BYTES : 0;
		check_value(32'(exp_fwd), fwd_seen.size(), $sformatf("forward count for %h", name));
		if (exp_fwd && fwd_seen.size() == 1)
			check_value(32'(name), 32'(fwd_seen[0]), "forwarded name");
		check_value(exp_unsol, unsol_seen, $sformatf("unsolicited count for %h", name));
		check_value(exp_bytes, out_seen.size(), $sformatf("served bytes for %h", name));
		if (exp_serve && out_seen.size() == `NDN_SLOT_BYTES)
		begin
			for (int i = 0; i < `NDN_SLOT_BYTES; i++)
			begin
				check_value(32'(m_content[idx][i]), 32'(out_seen[i]),
					$sformatf("served byte %0d of %h", i, name));
				if (i > 0)
					check_value(out_cycle[i-1] + 1, out_cycle[i], "out_valid gap");
			end
		end
		check_value(0, satisfied, "satisfied after event");
		fwd_seen.delete();
		out_seen.delete();
		out_cycle.delete();
		unsol_seen = 0;
		events_done++;
	endtask

	task automatic run_interest(input ndn_name_t name);
		logic [`NDN_INDEX_W-1:0] idx;
		logic                    hit;
		logic                    serve;
		idx = name[`NDN_INDEX_W-1:0];
		hit = model_hit(name);
		serve = hit && m_received[idx];
		if (!hit)
		begin
			// Claim the slot and evict whatever was there
			m_valid[idx] = 1'b1;
			m_received[idx] = 1'b0;
			m_tag[idx] = name[`NDN_NAME_W-1:`NDN_INDEX_W];
		end
		send_event(EV_INTEREST, name);
		@(posedge clk);
		check_value(1, busy, "busy while deciding");
		while (busy)
			@(posedge clk);
		@(negedge clk); // Monitor has seen the last pulse
		compare_outputs(!hit, name, serve, 0);
	endtask

	task automatic run_data(input ndn_name_t name);
		ndn_byte_t               payload [`NDN_SLOT_BYTES];
		logic [`NDN_INDEX_W-1:0] idx;
		logic                    store;
		int                      gap;
		idx = name[`NDN_INDEX_W-1:0];
		store = model_hit(name) && !m_received[idx];
		for (int i = 0; i < `NDN_SLOT_BYTES; i++)
			payload[i] = ndn_byte_t'($random(seed));
		send_event(EV_DATA, name);
		for (int i = 0; i < `NDN_SLOT_BYTES; i++)
		begin
			gap = {$random(seed)} % 3; // Idle cycles before this byte
			repeat (gap)
			begin
				in_valid <= 1'b0;
				@(posedge clk);
			end
			in_valid <= 1'b1;
			in_data <= payload[i];
			@(posedge clk);
		end
		in_valid <= 1'b0;
		@(posedge clk);
		check_value(0, busy, "busy after last data byte");
		@(negedge clk);
		if (store)
		begin
			m_received[idx] = 1'b1;
			for (int i = 0; i < `NDN_SLOT_BYTES; i++)
				m_content[idx][i] = payload[i];
		end
		compare_outputs(1'b0, name, 1'b0, store ? 0 : 1);
	endtask

	initial
	begin
		event_start = 1'b0;
		evt = '0;
		in_valid = 1'b0;
		in_data = '0;
		for (int s = 0; s < `NDN_SLOTS; s++)
		begin
			m_valid[s] = 1'b0;
			m_received[s] = 1'b0;
			m_tag[s] = '0;
			for (int b = 0; b < `NDN_SLOT_BYTES; b++)
				m_content[s][b] = '0;
		end
		@(negedge reset);
		repeat (2)
			@(posedge clk);
		@(negedge clk);
		check_value(0, busy, "busy after reset");
		check_value(0, forward_interest, "forward_interest after reset");
		check_value(0, unsolicited, "unsolicited after reset");
		check_value(0, out_valid, "out_valid after reset");
		check_value(0, satisfied, "satisfied after reset");

		run_interest(16'h1234); // New name is forwarded
		run_interest(16'h1234); // Still pending so aggregated
		run_data(16'h1234);
		run_interest(16'h1234); // Served from the buffer
		run_data(16'h5677);     // Nobody asked for it
		run_interest(16'h5677);
		run_interest(16'hab34); // Same index as 1234
		run_interest(16'h1234); // Evicted and forwarded again
		run_data(16'hab34);
		run_data(16'h1234);
		run_interest(16'h1234);

		for (int n = 0; n < RANDOM_EVENTS; n++)
		begin
			if ($random(seed) & 1)
				run_data(pick_name());
			else
				run_interest(pick_name());
		end

		$display("Events: %0d, checks: %0d, errors: %0d", events_done, checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	// Watchdog sized from the worst case event length
	initial
	begin
		repeat (MAX_EVENTS * CYCLES_PER_EVENT)
			@(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles",
			MAX_EVENTS * CYCLES_PER_EVENT);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

//--- dv/clock_gen.sv
`timescale 1ns/10ps

module clock_gen (
	output logic clk,
	output logic reset
);
	localparam int HALF_PERIOD = 50; // 100 ns clock

	initial
	begin
		clk = 1'b0;
		forever
			#HALF_PERIOD clk = ~clk;
	end

	// Reset held for the first 5 cycles
	initial
	begin
		reset = 1'b1;
		repeat (5)
			@(posedge clk);
		reset <= 1'b0;
	end

endmodule

//--- hdl/ndn_node.sv
`timescale 1ns/10ps

module ndn_node (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    event_start,
	input  ndn_pkt_pkg::ndn_event_t evt,
	input  logic                    in_valid,
	input  ndn_pkt_pkg::ndn_byte_t  in_data,
	output logic                    busy,
	output logic                    forward_interest,
	output ndn_pkt_pkg::ndn_name_t  forward_name,
	output logic                    unsolicited,
	output logic                    out_valid,
	output ndn_pkt_pkg::ndn_byte_t  out_data,
	output logic                    satisfied
);
	import ndn_pkt_pkg::*;
	import ndn_table_pkg::*;

	ndn_name_t   lookup_name;
	pit_entry_t  entry;
	pit_update_t update;
	buf_req_t    req;
	ndn_byte_t   rd_data;

	pit_table table_i (
		.clk         (clk),
		.reset       (reset),
		.lookup_name (lookup_name),
		.update      (update),
		.entry       (entry)
	);

	pit_controller controller_i (
		.clk              (clk),
		.reset            (reset),
		.event_start      (event_start),
		.evt              (evt),
		.in_valid         (in_valid),
		.in_data          (in_data),
		.entry            (entry),
		.rd_data          (rd_data),
		.lookup_name      (lookup_name),
		.update           (update),
		.req              (req),
		.busy             (busy),
		.forward_interest (forward_interest),
		.unsolicited      (unsolicited),
		.satisfied        (satisfied),
		.out_valid        (out_valid),
		.forward_name     (forward_name),
		.out_data         (out_data)
	);

	// Content store, one region per PIT slot
	content_buffer buffer_i (
		.clk     (clk),
		.req     (req),
		.rd_data (rd_data)
	);

endmodule

//--- hdl/pit_controller.sv
`timescale 1ns/10ps
`include "ndn_macros.svh"

module pit_controller (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       event_start,
	input  ndn_pkt_pkg::ndn_event_t    evt,
	input  logic                       in_valid,
	input  ndn_pkt_pkg::ndn_byte_t     in_data,
	input  ndn_table_pkg::pit_entry_t  entry,
	input  ndn_pkt_pkg::ndn_byte_t     rd_data,
	output ndn_pkt_pkg::ndn_name_t     lookup_name,
	output ndn_table_pkg::pit_update_t update,
	output ndn_table_pkg::buf_req_t    req,
	output logic                       busy,
	output logic                       forward_interest,
	output logic                       unsolicited,
	output logic                       satisfied,
	output logic                       out_valid,
	output ndn_pkt_pkg::ndn_name_t     forward_name,
	output ndn_pkt_pkg::ndn_byte_t     out_data
);
	import ndn_pkt_pkg::*;
	import ndn_table_pkg::*;

	typedef enum logic [2:0]
	{
		IDLE,
		RECEIVING,
		MEMORY_IN,
		MEMORY_OUT,
		DROPPING,
		RESET
	} state_t;

	localparam buf_offset_t LAST_BYTE = `NDN_BYTE_CNT_W'(`NDN_SLOT_BYTES - 1);

	state_t      state;
	ndn_event_t  ev_q;
	buf_offset_t byte_cnt;
	pit_index_t  slot;
	pit_tag_t    tag;
	logic        accept;
	logic        hit;
	logic        serve;
	logic        claim;
	logic        store;
	logic        last_in;

	// Events are taken while not busy, a drop in progress is abandoned
	assign accept = event_start && (state == IDLE || state == DROPPING);

	assign lookup_name = ev_q.name;
	assign slot = ev_q.name[`NDN_INDEX_W-1:0];
	assign tag = ev_q.name[`NDN_NAME_W-1:`NDN_INDEX_W];

	// Decision terms, only meaningful in RECEIVING
	assign hit = entry.valid && (entry.tag == tag);
	assign serve = (ev_q.kind == EV_INTEREST) && hit && entry.received;
	assign claim = (ev_q.kind == EV_INTEREST) && !hit;
	assign store = (ev_q.kind == EV_DATA) && hit && !entry.received;

	assign last_in = in_valid && (byte_cnt == LAST_BYTE);

	// Read data goes straight out, qualified by out_valid
	assign out_data = rd_data;

	// Table writes
	always_comb
	begin
		update = '0;
		update.index = slot;
		update.entry.valid = 1'b1;
		update.entry.tag = tag;
		if (state == RECEIVING && claim)
			update.we = 1'b1; // New pending entry
		if (state == MEMORY_IN && last_in)
		begin
			update.we = 1'b1;
			update.entry.received = 1'b1; // Store complete
		end
	end

	// Buffer access, a read whenever no byte is written
	always_comb
	begin
		req = '0;
		req.index = slot;
		req.offset = byte_cnt;
		req.wdata = in_data;
		req.we = in_valid && ((state == RECEIVING && store) || state == MEMORY_IN);
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= RESET;
			busy <= 1'b0;
			forward_interest <= 1'b0;
			unsolicited <= 1'b0;
			out_valid <= 1'b0;
			satisfied <= 1'b0;
			byte_cnt <= '0;
		end
		else
		begin
			forward_interest <= 1'b0;
			unsolicited <= 1'b0;
			out_valid <= (state == MEMORY_OUT); // One cycle behind each read

			case (state)
			IDLE:
			begin
				if (accept)
				begin
					state <= RECEIVING;
					busy <= 1'b1;
					byte_cnt <= '0;
				end
			end

			RECEIVING:
			begin
				if (serve)
				begin
					state <= MEMORY_OUT;
					satisfied <= 1'b1;
					byte_cnt <= '0;
				end
				else if (store)
				begin
					state <= MEMORY_IN;
					if (in_valid)
						byte_cnt <= byte_cnt + 1'b1; // First byte already written
				end
				else if (claim)
				begin
					state <= IDLE;
					busy <= 1'b0;
					forward_interest <= 1'b1;
				end
				else if (ev_q.kind == EV_DATA)
				begin
					// Nobody asked for it
					state <= DROPPING;
					busy <= 1'b0;
					unsolicited <= 1'b1;
					if (in_valid)
						byte_cnt <= byte_cnt + 1'b1;
				end
				else
				begin
					state <= IDLE; // Aggregated
					busy <= 1'b0;
				end
			end

			MEMORY_IN:
			begin
				if (last_in)
				begin
					state <= IDLE;
					busy <= 1'b0;
				end
				else if (in_valid)
					byte_cnt <= byte_cnt + 1'b1;
			end

			MEMORY_OUT:
			begin
				byte_cnt <= byte_cnt + 1'b1;
				if (byte_cnt == LAST_BYTE)
					state <= RESET; // Last byte still in flight
			end

			DROPPING:
			begin
				if (accept)
				begin
					state <= RECEIVING;
					busy <= 1'b1;
					byte_cnt <= '0;
				end
				else if (last_in)
					state <= IDLE;
				else if (in_valid)
					byte_cnt <= byte_cnt + 1'b1;
			end

			RESET:
			begin
				busy <= 1'b0;
				satisfied <= 1'b0;
				byte_cnt <= '0;
				state <= IDLE;
			end

			default:
				state <= RESET;
			endcase
		end
	end

	// Event and forwarded name
	always_ff @(posedge clk)
	begin
		if (accept)
			ev_q <= evt;
		if (state == RECEIVING && claim)
			forward_name <= ev_q.name; // Held until the next forward
	end

endmodule

//--- hdl/content_buffer.sv
`timescale 1ns/10ps
`include "ndn_macros.svh"

module content_buffer (
	input  logic                    clk,
	input  ndn_table_pkg::buf_req_t req,
	output ndn_pkt_pkg::ndn_byte_t  rd_data
);
	import ndn_pkt_pkg::*;

	// One region of NDN_SLOT_BYTES per table slot
	ndn_byte_t mem [`NDN_SLOTS * `NDN_SLOT_BYTES];
	logic [`NDN_INDEX_W+`NDN_BYTE_CNT_W-1:0] addr;

	assign addr = {req.index, req.offset};

	always_ff @(posedge clk)
	begin
		if (req.we)
			mem[addr] <= req.wdata;
		else
			rd_data <= mem[addr]; // Valid the cycle after the request
	end

endmodule

//--- hdl/pit_table.sv
`timescale 1ns/10ps
`include "ndn_macros.svh"

module pit_table (
	input  logic                       clk,
	input  logic                       reset,
	input  ndn_pkt_pkg::ndn_name_t     lookup_name,
	input  ndn_table_pkg::pit_update_t update,
	output ndn_table_pkg::pit_entry_t  entry
);
	import ndn_table_pkg::*;

	pit_entry_t entries [`NDN_SLOTS];
	pit_index_t lookup_index;

	// Direct mapped, the low name bits pick the slot
	assign lookup_index = lookup_name[`NDN_INDEX_W-1:0];

	// Raw entry goes back, tag compare is done by the controller
	assign entry = entries[lookup_index];

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < `NDN_SLOTS; i++)
				entries[i] <= '0; // All slots invalid
		end
		else if (update.we)
		begin
			// A colliding name just takes the slot over
			entries[update.index] <= update.entry;
		end
	end

endmodule

//--- hdl/ndn_table_pkg.sv
`include "ndn_macros.svh"

package ndn_table_pkg;

	typedef logic [`NDN_INDEX_W-1:0] pit_index_t;
	typedef logic [`NDN_NAME_W-`NDN_INDEX_W-1:0] pit_tag_t; // Upper name bits
	typedef logic [`NDN_BYTE_CNT_W-1:0] buf_offset_t;

	// One PIT slot
	typedef struct packed
	{
		logic     valid;
		logic     received; // Content for this name is in the buffer
		pit_tag_t tag;
	} pit_entry_t;

	// Whole-entry write into the table
	typedef struct packed
	{
		logic       we;
		pit_index_t index;
		pit_entry_t entry;
	} pit_update_t;

	// Content buffer access, a read when we is low
	typedef struct packed
	{
		logic                   we;
		pit_index_t             index;
		buf_offset_t            offset;
		ndn_pkt_pkg::ndn_byte_t wdata;
	} buf_req_t;

endpackage

//--- hdl/ndn_pkt_pkg.sv
`include "ndn_macros.svh"

package ndn_pkt_pkg;

	typedef logic [`NDN_NAME_W-1:0] ndn_name_t;

	typedef logic [7:0] ndn_byte_t;

	// Kind of packet that arrived on a face
	typedef enum logic
	{
		EV_INTEREST = 1'b0,
		EV_DATA     = 1'b1
	} ndn_kind_t;

	// Arrival event, kind in the top bit
	typedef struct packed
	{
		ndn_kind_t kind;
		ndn_name_t name;
	} ndn_event_t;

endpackage

//--- include/ndn_macros.svh
`ifndef NDN_MACROS_SVH
`define NDN_MACROS_SVH

// Name and table geometry
`define NDN_NAME_W 16
`define NDN_SLOTS 16

// Slot index is taken from the low name bits
`define NDN_INDEX_W 4

// Content held per slot
`define NDN_SLOT_BYTES 16
`define NDN_BYTE_CNT_W 4

`endif
